// File: tb.f
busPkg.sv
aluPkg.sv
wbCommandPort.sv
commandQueue.sv
binaryAlu.sv
decimalAdjust.sv
executeUnit.sv
accumulatorUnit.sv
tbClockGen.sv
tbAccumulatorUnit.sv

// File: Makefile
# Verilator build and run of the accumulator unit testbench

VERILATOR ?= verilator
TOP       ?= tbAccumulatorUnit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tbAccumulatorUnit.sv
// directed tests, reference model, compare tasks and timeout for the accumulator unit
`timescale 1ns/100ps

module tbAccumulatorUnit
    import aluPkg::*;
    import busPkg::*;
();

    // about 124 bus transfers of at most 16 cycles each, doubled for margin
    localparam int resetCycles       = 16;
    localparam int transferBudget    = 124;
    localparam int cyclesPerTransfer = 16;
    localparam int cycleLimit = 2 * (resetCycles + transferBudget * cyclesPerTransfer);

    logic                    phi2;
    logic                    rstAll;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [busAddrWidth-1:0] adr;
    logic [busDataWidth-1:0] datIn;
    logic [busDataWidth-1:0] datOut;
    logic                    ack;

    // reference copy of the accumulator and status
    logic [dataWidth-1:0] modelAcc;
    logic [dataWidth-1:0] modelStatus;
    int                   accErrors;
    int                   statusErrors;
    int                   cycleCount;
    int                   seed;

    tbClockGen #(.resetCycles(resetCycles)) tbClockGen_inst (
        .phi2   (phi2),
        .rstAll (rstAll)
    );

    accumulatorUnit accumulatorUnit_inst (
        .phi2   (phi2),
        .rstAll (rstAll),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datIn  (datIn),
        .datOut (datOut),
        .ack    (ack)
    );

    // each transfer starts and ends on a falling edge, ack is sampled there too
    task automatic busWrite(input logic [busAddrWidth-1:0] addr,
                            input logic [busDataWidth-1:0] data);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = addr;
        datIn = data;
        @(negedge phi2);
        while (!ack) begin
            @(negedge phi2);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic busRead(output logic [busDataWidth-1:0] data);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b0;
        adr   = addrResult;
        datIn = '0;
        @(negedge phi2);
        while (!ack) begin
            @(negedge phi2);
        end
        data = datOut;
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    function automatic string flagName(input int bitIndex);
        case (bitIndex)
            statusN:      return "N";
            statusV:      return "V";
            statusUnused: return "-";
            statusB:      return "B";
            statusD:      return "D";
            statusI:      return "I";
            statusZ:      return "Z";
            default:      return "C";
        endcase
    endfunction

    task automatic checkAcc(input logic [dataWidth-1:0] actual,
                            input logic [dataWidth-1:0] expected, input string what);
        if (actual !== expected) begin
            accErrors++;
            $display("[FAIL] %0t ns: %s accumulator expected %h, got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic checkStatus(input logic [dataWidth-1:0] actual,
                               input logic [dataWidth-1:0] expected, input string what);
        int i;
        if (actual !== expected) begin
            statusErrors++;
            for (i = dataWidth - 1; i >= 0; i--) begin
                if (actual[i] !== expected[i]) begin
                    $display("[FAIL] %0t ns: %s flag %s expected %b, got %b",
                             $time, what, flagName(i), expected[i], actual[i]);
                end
            end
        end
    endtask

    task automatic modelOperation(input logic [opCodeWidth-1:0] op,
                                  input logic [dataWidth-1:0] operand);
        logic [dataWidth-1:0] addend;
        logic [dataWidth-1:0] value;
        logic                 carryIn;
        logic                 carry;
        logic                 overflow;
        logic                 halfCarry;
        int                   sum;
        carryIn  = modelStatus[statusC];
        value    = modelAcc;
        carry    = carryIn;
        overflow = modelStatus[statusV];
        case (op)
            opLda: value = operand;
            opAnd: value = modelAcc & operand;
            opEor: value = modelAcc ^ operand;
            opOra: value = modelAcc | operand;
            opLsr: begin
                carry = modelAcc[0];
                value = modelAcc >> 1;
            end
            opRor: begin
                carry = modelAcc[0];
                value = {carryIn, modelAcc[dataWidth-1:1]};
            end
            opAdc, opSbc: begin
                // subtract adds the complement, carry set means no borrow
                addend    = (op == opSbc) ? ~operand : operand;
                halfCarry = (int'(modelAcc[3:0]) + int'(addend[3:0]) + int'(carryIn)) > 15;
                sum       = int'(modelAcc) + int'(addend) + int'(carryIn);
                value     = sum[dataWidth-1:0];
                carry     = sum > 255;
                overflow  = (modelAcc[7] == addend[7]) && (value[7] != modelAcc[7]);
                if (modelStatus[statusD] && op == opAdc) begin
                    carry = carry || (value > 8'h99);
                    if (value[3:0] > 4'd9 || halfCarry) begin
                        value = value + 8'h06;
                    end
                    if (carry) begin
                        value = value + 8'h60;
                    end
                end else if (modelStatus[statusD]) begin
                    if (!halfCarry) begin
                        value = value - 8'h06;
                    end
                    if (!carry) begin
                        value = value - 8'h60;
                    end
                end
            end
            default: value = modelAcc;
        endcase
        modelAcc             = value;
        modelStatus[statusN] = value[dataWidth-1];
        modelStatus[statusZ] = (value == '0);
        if (op == opAdc || op == opSbc || op == opLsr || op == opRor) begin
            modelStatus[statusC] = carry;
        end
        if (op == opAdc || op == opSbc) begin
            modelStatus[statusV] = overflow;
        end
    endtask

    task automatic sendOp(input logic [opCodeWidth-1:0] op, input logic [dataWidth-1:0] operand);
        commandWord cmd;
        cmd                = '0;
        cmd.opView.opCode  = op;
        cmd.opView.operand = operand;
        busWrite(addrOperation, cmd);
        modelOperation(op, operand);
    endtask

    task automatic loadStatus(input logic [dataWidth-1:0] image);
        commandWord cmd;
        cmd                      = '0;
        cmd.flagView.statusImage = image;
        busWrite(addrStatusLoad, cmd);
        // bit 5 always reads one, B is never stored
        modelStatus              = image;
        modelStatus[statusUnused] = 1'b1;
        modelStatus[statusB]      = 1'b0;
    endtask

    task automatic readAndCheck(input string what);
        logic [busDataWidth-1:0] word;
        busRead(word);
        checkAcc(word[dataWidth-1:0], modelAcc, what);
        checkStatus(word[busDataWidth-1:dataWidth], modelStatus, what);
    endtask

    task automatic testResetState();
        logic [busDataWidth-1:0] word;
        busRead(word);
        checkAcc(word[dataWidth-1:0], 8'h00, "reset");
        checkStatus(word[busDataWidth-1:dataWidth], 8'h20, "reset");
        modelAcc    = 8'h00;
        modelStatus = 8'h20;
    endtask

    // C and V come from the load and must survive logic ops
    task automatic testLogicAndLoad();
        loadStatus(8'hC1);
        sendOp(opLda, 8'h00);
        readAndCheck("lda zero");
        sendOp(opOra, 8'h80);
        readAndCheck("ora negative");
        sendOp(opAnd, 8'h0F);
        readAndCheck("and to zero");
        sendOp(opEor, 8'hA5);
        readAndCheck("eor");
    endtask

    task automatic testBinaryArithmetic();
        logic [31:0] draw;
        int          n;
        loadStatus(8'h00);
        for (n = 0; n < 40; n++) begin
            draw = $random(seed);
            sendOp(draw[0] ? opSbc : opAdc, draw[15:8]);
            readAndCheck(draw[0] ? "binary sbc" : "binary adc");
        end
    endtask

    // low bits 101 give carry-outs of one, zero and one in turn
    task automatic testShifts();
        loadStatus(8'h01);
        sendOp(opLda, 8'h85);
        sendOp(opLsr, 8'h00);
        readAndCheck("lsr carry out");
        sendOp(opRor, 8'h00);
        readAndCheck("ror carry in set");
        sendOp(opRor, 8'h00);
        readAndCheck("ror carry in clear");
    endtask

    task automatic testDecimalMode();
        logic [busDataWidth-1:0] word;
        loadStatus(8'h08);
        sendOp(opLda, 8'h58);
        sendOp(opAdc, 8'h46);
        // 58 + 46 wraps to 04 with a decimal carry
        busRead(word);
        checkAcc(word[dataWidth-1:0], 8'h04, "bcd 58+46");
        // V from the binary sum 0x9e, C from the decimal carry
        checkStatus(word[busDataWidth-1:dataWidth], 8'h69, "bcd 58+46");
        sendOp(opAdc, 8'h39);
        readAndCheck("bcd adc with carry");
        loadStatus(8'h09);
        sendOp(opLda, 8'h46);
        sendOp(opSbc, 8'h12);
        readAndCheck("bcd sbc no borrow");
        sendOp(opSbc, 8'h35);
        readAndCheck("bcd sbc borrow");
    endtask

    // decimal adds take three cycles against two per write, so the queue fills
    task automatic testBackPressure();
        int n;
        loadStatus(8'h08);
        sendOp(opLda, 8'h00);
        for (n = 0; n < 8; n++) begin
            sendOp(opAdc, 8'h19);
        end
        readAndCheck("bcd running sum");
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge phi2);
            cycleCount++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
        $display("Test failed");
        $finish;
    end

    initial begin
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        datIn        = '0;
        modelAcc     = '0;
        modelStatus  = 8'h20;
        accErrors    = 0;
        statusErrors = 0;
        seed         = 95;
        @(negedge rstAll);
        @(negedge phi2);
        testResetState();
        testLogicAndLoad();
        testBinaryArithmetic();
        testShifts();
        testDecimalMode();
        testBackPressure();
        $display("errors: accumulator %0d, status %0d, total %0d",
                 accErrors, statusErrors, accErrors + statusErrors);
        if (accErrors + statusErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tbClockGen.sv
// testbench clock and reset generator
`timescale 1ns/100ps

module tbClockGen #(
    parameter int halfPeriod  = 20,
    parameter int resetCycles = 16
) (
    output logic phi2,
    output logic rstAll
);

    initial begin
        phi2 = 1'b0;
        forever #halfPeriod phi2 = ~phi2;
    end

    // reset drops on a falling edge, away from the sampling edge
    initial begin
        rstAll = 1'b1;
        repeat (resetCycles) @(posedge phi2);
        @(negedge phi2);
        rstAll = 1'b0;
    end

endmodule

// File: accumulatorUnit.sv
// top level joining the Wishbone port, command queue and execute unit
`timescale 1ns/100ps

module accumulatorUnit
    import busPkg::*;
(
    input  logic                    phi2,
    input  logic                    rstAll,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [busAddrWidth-1:0] adr,
    input  logic [busDataWidth-1:0] datIn,
    output logic [busDataWidth-1:0] datOut,
    output logic                    ack
);

    logic                    pushValid;
    logic                    pushIsFlagLoad;
    logic [busDataWidth-1:0] pushWord;
    logic                    full;
    logic                    empty;
    logic                    headValid;
    logic                    headIsFlagLoad;
    logic [busDataWidth-1:0] headWord;
    logic                    pop;
    logic                    busy;
    // status in the high half, accumulator in the low half
    logic [busDataWidth-1:0] resultWord;

    wbCommandPort wbCommandPort_inst (
        .phi2           (phi2),
        .rstAll         (rstAll),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .datIn          (datIn),
        .datOut         (datOut),
        .ack            (ack),
        .full           (full),
        .queueEmpty     (empty),
        .busy           (busy),
        .accValue       (resultWord[busDataWidth/2-1:0]),
        .statusValue    (resultWord[busDataWidth-1:busDataWidth/2]),
        .pushValid      (pushValid),
        .pushIsFlagLoad (pushIsFlagLoad),
        .pushWord       (pushWord)
    );

    commandQueue commandQueue_inst (
        .phi2           (phi2),
        .rstAll         (rstAll),
        .pushValid      (pushValid),
        .pushIsFlagLoad (pushIsFlagLoad),
        .pushWord       (pushWord),
        .pop            (pop),
        .headValid      (headValid),
        .headIsFlagLoad (headIsFlagLoad),
        .headWord       (headWord),
        .full           (full),
        .empty          (empty)
    );

    executeUnit executeUnit_inst (
        .phi2           (phi2),
        .rstAll         (rstAll),
        .headValid      (headValid),
        .headIsFlagLoad (headIsFlagLoad),
        .headWord       (headWord),
        .pop            (pop),
        .busy           (busy),
        .accValue       (resultWord[busDataWidth/2-1:0]),
        .statusValue    (resultWord[busDataWidth-1:busDataWidth/2])
    );

endmodule

// File: executeUnit.sv
// hold register, accumulator, status register and command sequencing
`timescale 1ns/100ps

module executeUnit
    import aluPkg::*;
(
    input  logic                 phi2,
    input  logic                 rstAll,
    input  logic                 headValid,
    input  logic                 headIsFlagLoad,
    input  commandWord           headWord,
    output logic                 pop,
    output logic                 busy,
    output logic [dataWidth-1:0] accValue,
    output logic [dataWidth-1:0] statusValue
);

    logic [1:0]             phase;
    logic [dataWidth-1:0]   acc;
    logic [dataWidth-1:0]   status;
    logic [opCodeWidth-1:0] opCode;
    logic                   isArith;
    logic                   isShift;
    logic                   startOp;
    logic [dataWidth-1:0]   aluResult;
    logic                   aluCarry;
    logic                   aluOverflow;
    logic                   aluHalfCarry;
    logic [dataWidth-1:0]   adjusted;
    logic                   decimalCarry;
    // hold register between compute and commit
    logic [dataWidth-1:0]   heldResult;
    logic                   heldCarry;
    logic                   heldOverflow;
    logic                   heldHalfCarry;
    logic [dataWidth-1:0]   loadImage;
    logic [dataWidth-1:0]   commitStatus;

    // head entry stays put until popped, so it is read again at commit
    assign opCode  = headWord.opView.opCode;
    assign isArith = (opCode == opAdc) | (opCode == opSbc);
    assign isShift = (opCode == opLsr) | (opCode == opRor);
    assign startOp = (phase == phaseIdle) & headValid & ~headIsFlagLoad;

    binaryAlu binaryAlu_inst (
        .opCode    (opCode),
        .accIn     (acc),
        .operand   (headWord.opView.operand),
        .carryIn   (status[statusC]),
        .result    (aluResult),
        .carryOut  (aluCarry),
        .overflow  (aluOverflow),
        .halfCarry (aluHalfCarry)
    );

    decimalAdjust decimalAdjust_inst (
        .heldResult    (heldResult),
        .isSubtract    (opCode == opSbc),
        .heldCarry     (heldCarry),
        .heldHalfCarry (heldHalfCarry),
        .adjusted      (adjusted),
        .decimalCarry  (decimalCarry)
    );

    always_comb begin
        loadImage               = headWord.flagView.statusImage;
        loadImage[statusUnused] = 1'b1;
        loadImage[statusB]      = 1'b0;
        // N and Z always follow the value written
        commitStatus          = status;
        commitStatus[statusN] = heldResult[dataWidth-1];
        commitStatus[statusZ] = (heldResult == '0);
        if (isArith | isShift) begin
            commitStatus[statusC] = heldCarry;
        end
        if (isArith) begin
            commitStatus[statusV] = heldOverflow;
        end
    end

    // flag loads commit in the cycle they are seen
    assign pop  = (phase == phaseCommit) | ((phase == phaseIdle) & headValid & headIsFlagLoad);
    assign busy = (phase != phaseIdle);

    assign accValue    = acc;
    assign statusValue = status;

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            phase  <= phaseIdle;
            acc    <= '0;
            status <= statusResetValue;
        end else begin
            case (phase)
                phaseIdle: begin
                    if (headValid & headIsFlagLoad) begin
                        status <= loadImage;
                    end else if (headValid) begin
                        phase <= (isArith & status[statusD]) ? phaseAdjust : phaseCommit;
                    end
                end
                phaseAdjust: phase <= phaseCommit;
                phaseCommit: begin
                    acc    <= heldResult;
                    status <= commitStatus;
                    phase  <= phaseIdle;
                end
                default: phase <= phaseIdle;
            endcase
        end
    end

    // the adjust cycle folds the BCD result and carry back into the hold register
    always_ff @(posedge phi2) begin
        if (startOp) begin
            heldResult    <= aluResult;
            heldCarry     <= aluCarry;
            heldOverflow  <= aluOverflow;
            heldHalfCarry <= aluHalfCarry;
        end else if (phase == phaseAdjust) begin
            heldResult <= adjusted;
            heldCarry  <= decimalCarry;
        end
    end

endmodule

// File: decimalAdjust.sv
// BCD correction of a held add or subtract result
`timescale 1ns/100ps

module decimalAdjust
    import aluPkg::*;
(
    input  logic [dataWidth-1:0] heldResult,
    input  logic                 isSubtract,
    input  logic                 heldCarry,
    input  logic                 heldHalfCarry,
    output logic [dataWidth-1:0] adjusted,
    output logic                 decimalCarry
);

    logic lowFix;
    logic highFix;

    // add corrects on a digit above nine or a carry out of it,
    // subtract corrects wherever a digit borrowed
    assign lowFix  = isSubtract ? ~heldHalfCarry
                                : (heldResult[3:0] > 4'd9) | heldHalfCarry;
    assign highFix = isSubtract ? ~heldCarry
                                : heldCarry | (heldResult > 8'h99);

    always_comb begin
        adjusted = heldResult;
        if (isSubtract) begin
            if (lowFix) begin
                adjusted = adjusted - 8'h06;
            end
            if (highFix) begin
                adjusted = adjusted - 8'h60;
            end
        end else begin
            if (lowFix) begin
                adjusted = adjusted + 8'h06;
            end
            if (highFix) begin
                adjusted = adjusted + 8'h60;
            end
        end
    end

    // borrow state of a subtract is already right in the binary carry
    assign decimalCarry = isSubtract ? heldCarry : highFix;

endmodule

// File: binaryAlu.sv
// combinational 8-bit ALU with half-carry, carry and overflow
`timescale 1ns/100ps

module binaryAlu
    import aluPkg::*;
(
    input  logic [opCodeWidth-1:0] opCode,
    input  logic [dataWidth-1:0]   accIn,
    input  logic [dataWidth-1:0]   operand,
    input  logic                   carryIn,
    output logic [dataWidth-1:0]   result,
    output logic                   carryOut,
    output logic                   overflow,
    output logic                   halfCarry
);

    logic [dataWidth-1:0] addend;
    logic [4:0]           lowSum;
    logic [4:0]           highSum;

    // subtract is an add of the inverted operand, borrow is the inverted carry
    assign addend = (opCode == opSbc) ? ~operand : operand;

    always_comb begin
        result    = '0;
        carryOut  = 1'b0;
        overflow  = 1'b0;
        halfCarry = 1'b0;
        lowSum    = '0;
        highSum   = '0;
        case (opCode)
            opAdc, opSbc: begin
                // nibble at a time so the half-carry falls out
                lowSum    = {1'b0, accIn[3:0]} + {1'b0, addend[3:0]} + {4'b0, carryIn};
                halfCarry = lowSum[4];
                highSum   = {1'b0, accIn[7:4]} + {1'b0, addend[7:4]} + {4'b0, halfCarry};
                carryOut  = highSum[4];
                result    = {highSum[3:0], lowSum[3:0]};
                // same-sign addends giving a result of the other sign
                overflow  = (accIn[7] == addend[7]) & (result[7] != accIn[7]);
            end
            opAnd: result = accIn & operand;
            opEor: result = accIn ^ operand;
            opOra: result = accIn | operand;
            opLsr: begin
                result   = {1'b0, accIn[dataWidth-1:1]};
                carryOut = accIn[0];
            end
            opRor: begin
                result   = {carryIn, accIn[dataWidth-1:1]};
                carryOut = accIn[0];
            end
            opLda: result = operand;
            default: result = '0;
        endcase
    end

endmodule

// File: commandQueue.sv
// circular FIFO of pending commands with simultaneous push and pop
`timescale 1ns/100ps

module commandQueue
    import aluPkg::*;
(
    input  logic       phi2,
    input  logic       rstAll,
    input  logic       pushValid,
    input  logic       pushIsFlagLoad,
    input  commandWord pushWord,
    input  logic       pop,
    output logic       headValid,
    output logic       headIsFlagLoad,
    output commandWord headWord,
    output logic       full,
    output logic       empty
);

    commandWord                wordMem [queueDepth];
    logic [queueDepth-1:0]     flagLoadMem;
    logic [queueAddrWidth-1:0] wrPtr;
    logic [queueAddrWidth-1:0] rdPtr;
    logic [queueAddrWidth:0]   count;
    logic                      doPush;
    logic                      doPop;

    assign full  = (count == (queueAddrWidth + 1)'(queueDepth));
    assign empty = (count == '0);

    assign doPush = pushValid & ~full;
    assign doPop  = pop & ~empty;

    assign headValid      = ~empty;
    assign headWord       = wordMem[rdPtr];
    assign headIsFlagLoad = flagLoadMem[rdPtr];

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge phi2) begin
        if (doPush) begin
            wordMem[wrPtr]     <= pushWord;
            flagLoadMem[wrPtr] <= pushIsFlagLoad;
        end
    end

endmodule

// File: wbCommandPort.sv
// Wishbone classic slave that queues command writes and returns status and accumulator
`timescale 1ns/100ps

module wbCommandPort
    import aluPkg::*;
    import busPkg::*;
(
    input  logic                    phi2,
    input  logic                    rstAll,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [busAddrWidth-1:0] adr,
    input  commandWord              datIn,
    output logic [busDataWidth-1:0] datOut,
    output logic                    ack,
    input  logic                    full,
    input  logic                    queueEmpty,
    input  logic                    busy,
    input  logic [dataWidth-1:0]    accValue,
    input  logic [dataWidth-1:0]    statusValue,
    output logic                    pushValid,
    output logic                    pushIsFlagLoad,
    output commandWord              pushWord
);

    logic cycleActive;
    logic writeAccept;
    logic readAccept;

    // ack is still high on the edge the master sees it, so that edge is skipped
    assign cycleActive = cyc & stb & ~ack;

    // a full queue just delays the ack
    assign writeAccept = cycleActive & we & ~full;

    // reads wait until every accepted command has committed
    assign readAccept = cycleActive & ~we & queueEmpty & ~busy;

    assign pushValid      = writeAccept;
    assign pushIsFlagLoad = (adr == addrStatusLoad);
    assign pushWord       = datIn;

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            ack <= 1'b0;
        end else begin
            ack <= writeAccept | readAccept;
        end
    end

    // status in the high byte, accumulator in the low byte
    always_ff @(posedge phi2) begin
        if (readAccept) begin
            datOut <= {statusValue, accValue};
        end
    end

endmodule

// File: aluPkg.sv
// datapath widths, opcodes, status bit positions, queue depth, phases and the command word
package aluPkg;

    localparam int dataWidth   = 8;
    localparam int opCodeWidth = 4;

    // alu opcodes
    localparam logic [opCodeWidth-1:0] opLda = 4'd0;
    localparam logic [opCodeWidth-1:0] opAdc = 4'd1;
    localparam logic [opCodeWidth-1:0] opSbc = 4'd2;
    localparam logic [opCodeWidth-1:0] opAnd = 4'd3;
    localparam logic [opCodeWidth-1:0] opEor = 4'd4;
    localparam logic [opCodeWidth-1:0] opOra = 4'd5;
    localparam logic [opCodeWidth-1:0] opLsr = 4'd6;
    localparam logic [opCodeWidth-1:0] opRor = 4'd7;

    // status layout NV-BDIZC
    localparam int statusN      = 7;
    localparam int statusV      = 6;
    localparam int statusUnused = 5;
    localparam int statusB      = 4;
    localparam int statusD      = 3;
    localparam int statusI      = 2;
    localparam int statusZ      = 1;
    localparam int statusC      = 0;

    localparam logic [dataWidth-1:0] statusResetValue = 8'h20;

    localparam int queueDepth     = 4;
    localparam int queueAddrWidth = 2;

    // execute unit phases
    localparam logic [1:0] phaseIdle   = 2'd0;
    localparam logic [1:0] phaseAdjust = 2'd1;
    localparam logic [1:0] phaseCommit = 2'd2;

    // one bus word, read either as an alu command or as a status image
    typedef union packed {
        struct packed {
            logic [opCodeWidth-1:0] opCode;
            logic [3:0]             reserved;
            logic [dataWidth-1:0]   operand;
        } opView;
        struct packed {
            logic [dataWidth-1:0] reserved;
            logic [dataWidth-1:0] statusImage;
        } flagView;
    } commandWord;

endpackage

// File: busPkg.sv
// Wishbone word widths and register map of the accumulator unit
package busPkg;

    // data word carries a command on writes, status and accumulator on reads
    localparam int busDataWidth = 16;
    localparam int busAddrWidth = 2;

    // write addresses
    localparam logic [busAddrWidth-1:0] addrOperation  = 2'd0;
    localparam logic [busAddrWidth-1:0] addrStatusLoad = 2'd1;

    // read address, though any address returns the same word
    localparam logic [busAddrWidth-1:0] addrResult     = 2'd2;

endpackage
